/* filelist.f */
hdl/btb_pkg.sv
hdl/btb_way_array.sv
hdl/btb_plru.sv
hdl/btb_update_ctrl.sv
hdl/btb_lookup.sv
hdl/btb_top.sv
verif/tb_clock.sv
verif/btb_asserts.sv
verif/btb_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = btb_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+1000
SOURCES   = $(wildcard hdl/*.sv verif/*.sv)
PASS_MSG  = RESULT: PASS

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/btb_tb.sv */
module btb_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import btb_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int RANDOM_CYCLES = 420;
	localparam opcode_t OP_ADD = 4'b0001;

	logic clk;
	logic rst_n;
	word_t pc_if;
	word_t pc_wb;
	word_t target_wb;
	opcode_t opcode_wb;
	logic valid_wb;
	word_t predict_target;
	logic predict_hit;

	// reference model of the buffer contents
	logic m_valid [NUM_SETS][NUM_WAYS] = '{default: 1'b0};
	tag_t m_tag [NUM_SETS][NUM_WAYS];
	word_t m_tgt [NUM_SETS][NUM_WAYS];
	plru_t m_plru [NUM_SETS] = '{default: '0};

	int mismatches = 0;
	int cycles = 0;
	string test_name = "reset";
	// name of the test whose inputs are on the bus this cycle
	string check_name = "reset";
	logic [15:0] lfsr = 16'd40154;
	// mix of branch-class and other opcodes for random traffic
	opcode_t ops [8] = '{OP_BR, OP_JMP, OP_JSR, OP_TRAP, OP_ADD, 4'b0110, OP_BR, OP_JSR};

	tb_clock u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	btb_top uut (
		.clk            (clk),
		.rst_n          (rst_n),
		.pc_if          (pc_if),
		.pc_wb          (pc_wb),
		.target_wb      (target_wb),
		.opcode_wb      (opcode_wb),
		.valid_wb       (valid_wb),
		.predict_target (predict_target),
		.predict_hit    (predict_hit)
	);

	bind btb_top btb_asserts u_asserts (
		.clk            (clk),
		.rst_n          (rst_n),
		.pc_if          (pc_if),
		.predict_target (predict_target),
		.predict_hit    (predict_hit),
		.opcode_wb      (opcode_wb),
		.valid_wb       (valid_wb),
		.upd_we         (upd_we),
		.touch          (touch)
	);

	// fibonacci lfsr x^16+x^14+x^13+x^11+1
	// stepped once per bit taken
	function automatic logic [15:0] take_bits(int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			r = {r[14:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic word_t make_pc(tag_t t, index_t s);
		return {t, s, 1'b0};
	endfunction

	// small tag space per set so random traffic both hits and evicts
	function automatic word_t rand_pc();
		logic [15:0] r;
		r = take_bits(8);
		return make_pc({7'h2d, r[7:5]}, r[4:0]);
	endfunction

	function automatic logic is_branch_op(opcode_t op);
		return op == OP_BR || op == OP_JMP || op == OP_JSR || op == OP_TRAP;
	endfunction

	// tree walk toward the least recently used leaf
	function automatic int victim_of(plru_t p);
		return p[2] ? (p[1] ? 0 : 1) : (p[0] ? 2 : 3);
	endfunction

	// point root and pair node away from the used way
	function automatic plru_t touched(plru_t p, int way);
		plru_t n;
		n = p;
		n[2] = (way >= 2);
		if (way < 2) begin
			n[1] = (way == 1);
		end else begin
			n[0] = (way == 3);
		end
		return n;
	endfunction

	// hit rewrites the target, miss fills the victim, both touch
	function automatic void model_update(word_t pc, word_t tgt);
		index_t s;
		tag_t t;
		int way;
		s = pc[INDEX_LSB +: INDEX_W];
		t = pc[TAG_LSB +: TAG_W];
		way = -1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way < 0 && m_valid[s][w] && m_tag[s][w] == t) begin
				way = w;
			end
		end
		if (way < 0) begin
			way = victim_of(m_plru[s]);
		end
		m_valid[s][way] = 1'b1;
		m_tag[s][way] = t;
		m_tgt[s][way] = tgt;
		m_plru[s] = touched(m_plru[s], way);
	endfunction

	task automatic check_lookup();
		index_t s;
		logic exp_hit;
		word_t exp_tgt;
		s = pc_if[INDEX_LSB +: INDEX_W];
		exp_hit = 1'b0;
		exp_tgt = pc_if;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (!exp_hit && m_valid[s][w] && m_tag[s][w] == pc_if[TAG_LSB +: TAG_W]) begin
				exp_hit = 1'b1;
				exp_tgt = m_tgt[s][w];
			end
		end
		if (predict_hit !== exp_hit) begin
			mismatches++;
			$display("Mismatch %s: predict_hit expected %0b actual %0b (pc_if %h)",
				check_name, exp_hit, predict_hit, pc_if);
		end
		if (predict_target !== exp_tgt) begin
			mismatches++;
			$display("Mismatch %s: predict_target expected %h actual %h (pc_if %h)",
				check_name, exp_tgt, predict_target, pc_if);
		end
	endtask

	// outputs settle by the falling edge
	// the inputs seen here are sampled at the next rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			check_lookup();
			if (valid_wb && is_branch_op(opcode_wb)) begin
				model_update(pc_wb, target_wb);
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: stimulus still running after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic step(word_t f_pc, word_t w_pc, word_t w_tgt, opcode_t op, logic v);
		@(posedge clk);
		pc_if <= f_pc;
		pc_wb <= w_pc;
		target_wb <= w_tgt;
		opcode_wb <= op;
		valid_wb <= v;
		check_name <= test_name;
	endtask

	task automatic lookup(word_t pc);
		step(pc, '0, '0, OP_ADD, 1'b0);
	endtask

	// fetch the same pc in the update cycle
	// the lookup must still see the old contents
	task automatic train(word_t pc, word_t tgt);
		step(pc, pc, tgt, OP_BR, 1'b1);
	endtask

	initial begin
		word_t p;
		word_t f;
		word_t w;
		word_t t;
		logic [15:0] r;
		pc_if <= '0;
		pc_wb <= '0;
		target_wb <= '0;
		opcode_wb <= OP_ADD;
		valid_wb <= 1'b0;
		@(posedge rst_n);

		// empty buffer misses everywhere
		for (int i = 0; i < 8; i++) begin
			lookup(make_pc(tag_t'(i * 37), index_t'(i * 5)));
		end

		test_name = "train";
		p = make_pc(10'h155, 5'd3);
		train(p, 16'h1234);
		lookup(p);
		train(p, 16'h4321);
		lookup(p);

		// non-branch opcode and low valid_wb leave the buffer alone
		test_name = "ignore";
		p = make_pc(10'h2aa, 5'd3);
		step(p, p, 16'hbeef, OP_ADD, 1'b1);
		step(p, p, 16'hbeef, OP_JMP, 1'b0);
		lookup(p);

		// fifth tag in one set evicts the first
		test_name = "evict";
		for (int i = 0; i < 5; i++) begin
			train(make_pc(tag_t'(10'h100 + i), 5'd7), word_t'(16'h7000 + i));
		end
		for (int i = 0; i < 5; i++) begin
			lookup(make_pc(tag_t'(10'h100 + i), 5'd7));
		end

		// touching the first tag moves the eviction to the second
		test_name = "touch";
		for (int i = 0; i < 4; i++) begin
			train(make_pc(tag_t'(10'h200 + i), 5'd9), word_t'(16'h9000 + i));
		end
		train(make_pc(10'h200, 5'd9), 16'h9a00);
		train(make_pc(10'h204, 5'd9), 16'h9004);
		for (int i = 0; i < 5; i++) begin
			lookup(make_pc(tag_t'(10'h200 + i), 5'd9));
		end

		test_name = "random";
		repeat (RANDOM_CYCLES) begin
			f = rand_pc();
			w = rand_pc();
			t = take_bits(16);
			r = take_bits(5);
			step(f, w, t, ops[r[2:0]], r[4:3] != 2'b00);
		end
		lookup('0);
		repeat (2) @(posedge clk);

		$display("errors: %0d mismatches, %0d assertion failures",
			mismatches, uut.u_asserts.fail_count);
		if (mismatches == 0 && uut.u_asserts.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* verif/btb_asserts.sv */
module btb_asserts (
	input logic             clk,
	input logic             rst_n,
	input btb_pkg::word_t   pc_if,
	input btb_pkg::word_t   predict_target,
	input logic             predict_hit,
	input btb_pkg::opcode_t opcode_wb,
	input logic             valid_wb,
	input logic             upd_we [btb_pkg::NUM_WAYS],
	input logic             touch
);
	timeunit 1ns;
	timeprecision 100ps;
	import btb_pkg::*;

	// read by the testbench for the closing error line
	int fail_count = 0;
	logic [NUM_WAYS-1:0] we_vec;
	logic qualified;

	// packed copy of the write enables
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			we_vec[w] = upd_we[w];
		end
	end

	// valid branch-class writeback
	assign qualified = valid_wb && (opcode_wb inside {OP_BR, OP_JMP, OP_JSR, OP_TRAP});

	// a miss forwards the fetch pc unchanged
	miss_passes_pc: assert property (@(posedge clk) disable iff (!rst_n)
		!predict_hit |-> predict_target == pc_if)
		else begin
			fail_count = fail_count + 1;
			$error("predict_target differs from pc_if on a miss");
		end

	// never more than one way written per cycle
	one_write_max: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(we_vec))
		else begin
			fail_count = fail_count + 1;
			$error("more than one way write enable is high");
		end

	// no write without a qualified writeback
	no_stray_write: assert property (@(posedge clk) disable iff (!rst_n)
		!qualified |-> we_vec == '0)
		else begin
			fail_count = fail_count + 1;
			$error("way written without a valid branch writeback");
		end

	// every qualified writeback writes one way and touches the tree
	update_writes: assert property (@(posedge clk) disable iff (!rst_n)
		qualified |-> touch && $onehot(we_vec))
		else begin
			fail_count = fail_count + 1;
			$error("valid branch writeback did not write exactly one way");
		end

endmodule

/* verif/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// free-running clock, 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held low for the first 8 rising edges
	initial begin
		rst_n <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* hdl/btb_top.sv */
module btb_top (
	input  logic             clk,
	input  logic             rst_n,
	input  btb_pkg::word_t   pc_if,
	input  btb_pkg::word_t   pc_wb,
	input  btb_pkg::word_t   target_wb,
	input  btb_pkg::opcode_t opcode_wb,
	input  logic             valid_wb,
	output btb_pkg::word_t   predict_target,
	output logic             predict_hit
);
	import btb_pkg::*;

	index_t if_index;
	index_t wb_index;
	tag_t wb_tag;
	tag_t if_tags [NUM_WAYS];
	tag_t wb_tags [NUM_WAYS];
	word_t if_targets [NUM_WAYS];
	logic if_valid [NUM_WAYS];
	logic upd_we [NUM_WAYS];
	logic touch;
	way_t touch_way;
	way_t victim;

	// set index for both pipeline ends, tag for the array write data
	assign if_index = pc_if[INDEX_LSB +: INDEX_W];
	assign wb_index = pc_wb[INDEX_LSB +: INDEX_W];
	assign wb_tag = pc_wb[TAG_LSB +: TAG_W];

	btb_update_ctrl u_update (
		.clk         (clk),
		.rst_n       (rst_n),
		.pc_wb       (pc_wb),
		.opcode_wb   (opcode_wb),
		.valid_wb    (valid_wb),
		.wb_tags     (wb_tags),
		.victim      (victim),
		.fetch_index (if_index),
		.fetch_valid (if_valid),
		.upd_we      (upd_we),
		.touch       (touch),
		.touch_way   (touch_way)
	);

	// tag and target storage, one pair of arrays per way
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		btb_way_array #(.payload_t(tag_t)) u_tag (
			.clk        (clk),
			.we         (upd_we[w]),
			.wr_index   (wb_index),
			.wr_data    (wb_tag),
			.rd_index_a (if_index),
			.rd_data_a  (if_tags[w]),
			.rd_index_b (wb_index),
			.rd_data_b  (wb_tags[w])
		);

		// writeback-side target read has no consumer
		btb_way_array #(.payload_t(word_t)) u_target (
			.clk        (clk),
			.we         (upd_we[w]),
			.wr_index   (wb_index),
			.wr_data    (target_wb),
			.rd_index_a (if_index),
			.rd_data_a  (if_targets[w]),
			.rd_index_b (wb_index),
			.rd_data_b  ()
		);
	end

	// replacement state is read and touched at the writeback set
	btb_plru u_plru (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_index  (wb_index),
		.victim    (victim),
		.touch     (touch),
		.touch_way (touch_way)
	);

	btb_lookup u_lookup (
		.pc_if          (pc_if),
		.if_tags        (if_tags),
		.if_targets     (if_targets),
		.if_valid       (if_valid),
		.predict_target (predict_target),
		.predict_hit    (predict_hit)
	);

endmodule

/* hdl/btb_lookup.sv */
module btb_lookup (
	input  btb_pkg::word_t pc_if,
	input  btb_pkg::tag_t  if_tags [btb_pkg::NUM_WAYS],
	input  btb_pkg::word_t if_targets [btb_pkg::NUM_WAYS],
	input  logic           if_valid [btb_pkg::NUM_WAYS],
	output btb_pkg::word_t predict_target,
	output logic           predict_hit
);
	import btb_pkg::*;

	// tag of the fetch pc
	tag_t if_tag;
	// per-way match of the fetch set
	logic [NUM_WAYS-1:0] if_match;
	// way whose target is forwarded
	way_t hit_way;

	assign if_tag = pc_if[TAG_LSB +: TAG_W];

	// compare the fetch tag against every valid way of the set
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if_match[w] = if_valid[w] && (if_tags[w] == if_tag);
		end
	end

	// priority select, lowest matching way wins
	// walking downward lets the lowest index overwrite the others
	always_comb begin
		hit_way = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (if_match[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign predict_hit = |if_match;

	// on a miss fetch simply continues at the current pc
	// the fetch stage adds its own increment
	always_comb begin
		if (predict_hit) begin
			predict_target = if_targets[hit_way];
		end else begin
			predict_target = pc_if;
		end
	end

endmodule

/* hdl/btb_update_ctrl.sv */
module btb_update_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  btb_pkg::word_t   pc_wb,
	input  btb_pkg::opcode_t opcode_wb,
	input  logic             valid_wb,
	input  btb_pkg::tag_t    wb_tags [btb_pkg::NUM_WAYS],
	input  btb_pkg::way_t    victim,
	input  btb_pkg::index_t  fetch_index,
	output logic             fetch_valid [btb_pkg::NUM_WAYS],
	output logic             upd_we [btb_pkg::NUM_WAYS],
	output logic             touch,
	output btb_pkg::way_t    touch_way
);
	import btb_pkg::*;

	index_t wb_index;
	tag_t wb_tag;
	logic is_branch;
	logic qualified;
	// valid bit per set and way
	logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
	logic [NUM_WAYS-1:0] wb_match;
	logic wb_hit;
	way_t hit_way;
	way_t sel_way;

	assign wb_index = pc_wb[INDEX_LSB +: INDEX_W];
	assign wb_tag = pc_wb[TAG_LSB +: TAG_W];

	// only retiring control-flow instructions train the buffer
	assign is_branch = (opcode_wb == OP_BR) || (opcode_wb == OP_JMP) ||
		(opcode_wb == OP_JSR) || (opcode_wb == OP_TRAP);
	assign qualified = valid_wb && is_branch;

	// writeback-side hit detection
	// at most one way can match since fills only happen on a miss
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			wb_match[w] = valid_q[wb_index][w] && (wb_tags[w] == wb_tag);
		end
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (wb_match[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign wb_hit = |wb_match;
	// hit rewrites the target in place, miss replaces the plru victim
	assign sel_way = wb_hit ? hit_way : victim;

	// one-hot write enable into the tag and target arrays
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			upd_we[w] = qualified && (sel_way == way_t'(w));
		end
	end

	// the written way becomes most recently used on hit and fill alike
	assign touch = qualified;
	assign touch_way = sel_way;

	// valid bit is set by a fill and never cleared except by reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '{default: '0};
		end else if (qualified && !wb_hit) begin
			valid_q[wb_index][victim] <= 1'b1;
		end
	end

	// valid bits of the fetch set for the lookup stage
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			fetch_valid[w] = valid_q[fetch_index][w];
		end
	end

endmodule

/* hdl/btb_plru.sv */
module btb_plru (
	input  logic            clk,
	input  logic            rst_n,
	input  btb_pkg::index_t rd_index,
	output btb_pkg::way_t   victim,
	input  logic            touch,
	input  btb_pkg::way_t   touch_way
);
	import btb_pkg::*;

	// tree state per set
	plru_t state [NUM_SETS];
	// state of the addressed set and its successor after a touch
	plru_t cur;
	plru_t nxt;

	assign cur = state[rd_index];

	// follow the tree toward the least recently used leaf
	always_comb begin
		if (cur[PLRU_ROOT]) begin
			// root points left
			victim = cur[PLRU_LEFT] ? way_t'(0) : way_t'(1);
		end else begin
			// root points right
			victim = cur[PLRU_RIGHT] ? way_t'(2) : way_t'(3);
		end
	end

	// touch points every node on the path away from the used way
	// the node of the other pair keeps its value
	always_comb begin
		nxt = cur;
		case (touch_way)
			2'd0: begin
				nxt[PLRU_ROOT] = 1'b0;
				nxt[PLRU_LEFT] = 1'b0;
			end
			2'd1: begin
				nxt[PLRU_ROOT] = 1'b0;
				nxt[PLRU_LEFT] = 1'b1;
			end
			2'd2: begin
				nxt[PLRU_ROOT] = 1'b1;
				nxt[PLRU_RIGHT] = 1'b0;
			end
			default: begin
				nxt[PLRU_ROOT] = 1'b1;
				nxt[PLRU_RIGHT] = 1'b1;
			end
		endcase
	end

	// all sets start at 000, so the first fill lands in way 3
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= '{default: '0};
		end else if (touch) begin
			state[rd_index] <= nxt;
		end
	end

endmodule

/* hdl/btb_way_array.sv */
module btb_way_array #(
	parameter type payload_t = btb_pkg::word_t
) (
	input  logic            clk,
	input  logic            we,
	input  btb_pkg::index_t wr_index,
	input  payload_t        wr_data,
	input  btb_pkg::index_t rd_index_a,
	output payload_t        rd_data_a,
	input  btb_pkg::index_t rd_index_b,
	output payload_t        rd_data_b
);
	import btb_pkg::*;

	// one entry per set for this way
	// contents are meaningless until the matching valid bit is set
	payload_t mem [NUM_SETS];

	// single write port
	// written at writeback when this way is picked for hit or fill
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_index] <= wr_data;
		end
	end

	// port a serves the fetch-side lookup
	// asynchronous so the prediction comes out in the fetch cycle
	assign rd_data_a = mem[rd_index_a];

	// port b serves the writeback-side tag compare
	// a write in this cycle is not yet visible here
	assign rd_data_b = mem[rd_index_b];

endmodule

/* hdl/btb_pkg.sv */
package btb_pkg;

	// lc-3b machine word, used for pcs and branch targets
	localparam int WORD_W = 16;
	typedef logic [WORD_W-1:0] word_t;

	// instruction opcode field
	localparam int OPCODE_W = 4;
	typedef logic [OPCODE_W-1:0] opcode_t;

	// buffer geometry
	localparam int NUM_SETS = 32;
	localparam int NUM_WAYS = 4;

	// pc fields
	// bit 0 is always zero for word-aligned fetch, so the index starts at bit 1
	localparam int INDEX_W = 5;
	localparam int TAG_W = 10;
	localparam int INDEX_LSB = 1;
	localparam int TAG_LSB = 6;

	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] tag_t;

	// way number within a set
	typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

	// tree pseudo-lru state, one bit per internal node
	typedef logic [NUM_WAYS-2:0] plru_t;

	// node positions inside plru_t
	// left pair covers ways 0 and 1, right pair ways 2 and 3
	localparam int PLRU_ROOT = 2;
	localparam int PLRU_LEFT = 1;
	localparam int PLRU_RIGHT = 0;

	// branch-class opcodes that update the buffer at writeback
	localparam opcode_t OP_BR = 4'b0000;
	localparam opcode_t OP_JMP = 4'b1100;
	localparam opcode_t OP_JSR = 4'b0100;
	localparam opcode_t OP_TRAP = 4'b1111;

endpackage
